// ==== Makefile ====
TOP := sram_tester_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== include/sram_tester_macros.svh ====
`ifndef SRAM_TESTER_MACROS_SVH
`define SRAM_TESTER_MACROS_SVH

// Default SRAM geometry, one data word per address
`define SRAM_ADDR_BITS_DEFAULT 20
`define SRAM_DATA_BITS_DEFAULT 16

// Width of one board debug pin group
`define DEBUG_GROUP_BITS 8

`endif

// ==== tb/sram_model.sv ====
`timescale 1ns/10ps

module sram_model #(
  parameter int ADDR_BITS = 6,
  parameter int DATA_BITS = 16
) (
  input  logic [ADDR_BITS-1:0] addr,
  inout  wire  [DATA_BITS-1:0] data,
  input  logic                 ce_n,
  input  logic                 we_n,
  input  logic                 oe_n,
  input  logic                 fault_en,
  input  logic [ADDR_BITS-1:0] fault_addr,
  input  logic [DATA_BITS-1:0] stuck_data
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];
  logic [DATA_BITS-1:0] rd_word;
  logic                 drive;

  // Power-up contents, the inverted address
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = ~DATA_BITS'(a);
    end
  end

  // A stuck cell returns its fixed value whatever was written
  assign rd_word = (fault_en && addr == fault_addr) ? stuck_data : mem[addr];
  assign drive   = !ce_n && !oe_n && we_n;
  assign data    = drive ? rd_word : {DATA_BITS{1'bz}};

  // Write completes on the rising edge of WE
  always @(posedge we_n) begin
    if (!ce_n) begin
      mem[addr] <= data;
    end
  end

endmodule

// ==== tb/sram_tester_asserts.sv ====
`timescale 1ns/10ps

module sram_tester_asserts (
  input logic                       clk,
  input logic                       reset,
  input logic                       we_n,
  input logic                       oe_n,
  input logic                       data_oe,
  input sram_bus_pkg::bus_phase_t   phase,
  input logic                       led_done,
  input logic                       led_pass
);

  int fire_count = 0;

  // Both strobes low would make the SRAM and controller fight over the bus
  strobe_excl: assert property (@(posedge clk) disable iff (reset) !(!we_n && !oe_n))
    else begin
      fire_count++;
      $error("we_n and oe_n are low together");
    end

  // Write data held only during WE and one finish phase after it
  data_drive: assert property (@(posedge clk) disable iff (reset)
      data_oe |-> (!we_n || (phase == sram_bus_pkg::PH_FINISH && $past(!we_n))))
    else begin
      fire_count++;
      $error("data_bus driven outside a write strobe");
    end

  pass_needs_done: assert property (@(posedge clk) disable iff (reset)
      $rose(led_pass) |-> led_done)
    else begin
      fire_count++;
      $error("led_pass rose without led_done");
    end

endmodule

// ==== tb/sram_tester_tb.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module sram_tester_tb;

  localparam int ADDR_BITS = 6;
  localparam int DATA_BITS = 16;
  localparam int GB = `DEBUG_GROUP_BITS;
  localparam int HALF = ADDR_BITS / 2;
  localparam int DEPTH = 1 << ADDR_BITS;
  localparam int NUM_ROWS = 5;
  // Four cycles per access with a write and a read pass per pattern
  localparam int FULL_RUN = sram_test_pkg::PATTERN_COUNT * 2 * DEPTH * 4;
  localparam int RUN_TIMEOUT = 2 * FULL_RUN;
  localparam int HOLD_CYCLES = DEPTH * 4 + 32;

  typedef struct packed {
    logic                 read_only;
    logic                 fault_en;
    logic [ADDR_BITS-1:0] fault_addr;
    logic [DATA_BITS-1:0] stuck;
    logic                 extra_start;
    logic                 exp_pass;
    logic [ADDR_BITS-1:0] exp_fail_addr;
    logic [DATA_BITS-1:0] exp_rd;
  } row_t;

  row_t rows [NUM_ROWS];
  logic clk, reset, start, read_only, led_done, led_pass;
  logic sram_cs_n, sram_oe_n, sram_we_n, fault_en;
  logic [ADDR_BITS-1:0] sram_addr, fault_addr;
  wire  [DATA_BITS-1:0] sram_data;
  logic [DATA_BITS-1:0] stuck_data;
  logic [GB-1:0] ba_pins, dc_pins, kl_pins, hg_pins, lk_pins;
  int seed = 37148;
  int checks = 0;
  int errors = 0;
  bit timed_out = 1'b0;

  sram_tester_top #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) UUT (
    .clk(clk), .reset(reset), .start(start), .read_only(read_only),
    .led_done(led_done), .led_pass(led_pass),
    .sram_addr_bus(sram_addr), .sram_data_bus(sram_data),
    .sram_cs_n(sram_cs_n), .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
    .ba_pins(ba_pins), .dc_pins(dc_pins), .kl_pins(kl_pins),
    .hg_pins(hg_pins), .lk_pins(lk_pins)
  );

  sram_model #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_sram (
    .addr(sram_addr), .data(sram_data), .ce_n(sram_cs_n), .we_n(sram_we_n),
    .oe_n(sram_oe_n), .fault_en(fault_en), .fault_addr(fault_addr),
    .stuck_data(stuck_data)
  );

  bind sram_tester_top sram_tester_asserts u_asserts (
    .clk(clk), .reset(reset), .we_n(sram_we_n), .oe_n(sram_oe_n),
    .data_oe(u_bus.data_oe), .phase(u_bus.phase),
    .led_done(led_done), .led_pass(led_pass)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Address pattern is the address zero-extended to a data word
  function automatic logic [DATA_BITS-1:0] addr_word(input logic [ADDR_BITS-1:0] a);
    return DATA_BITS'(a);
  endfunction

  // Inverted checkerboard is the last pattern a full run leaves behind
  function automatic logic [DATA_BITS-1:0] inv_checker_word(input logic [ADDR_BITS-1:0] a);
    return a[0] ? {(DATA_BITS/2){2'b01}} : {(DATA_BITS/2){2'b10}};
  endfunction

  function automatic logic [ADDR_BITS-1:0] reverse_addr(input logic [ADDR_BITS-1:0] a);
    logic [ADDR_BITS-1:0] r;
    for (int i = 0; i < ADDR_BITS; i++) begin
      r[i] = a[ADDR_BITS-1-i];
    end
    return r;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic build_table();
    int rnd;
    logic [ADDR_BITS-1:0] fa;
    logic [DATA_BITS-1:0] w;
    rnd = $random(seed);
    fa = ADDR_BITS'(unsigned'(rnd) % DEPTH);
    w = addr_word(fa);
    rows[0] = '{1'b0, 1'b0, '0, '0, 1'b0, 1'b1, '0, '0};
    // Memory still holds the inverted checkerboard, so address 0 fails
    rows[1] = '{1'b1, 1'b0, '0, '0, 1'b0, 1'b0, '0, inv_checker_word('0)};
    rows[2] = '{1'b0, 1'b1, fa, {8'hA5, ~w[7:0]}, 1'b0, 1'b0, fa, {8'hA5, ~w[7:0]}};
    // The faulted run stopped after writing the address pattern
    rows[3] = '{1'b1, 1'b0, '0, '0, 1'b0, 1'b1, '0, '0};
    rows[4] = '{1'b0, 1'b0, '0, '0, 1'b1, 1'b1, '0, '0};
  endtask

  task automatic pulse_start(input logic ro);
    read_only = ro;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_row(input int r);
    bit seen;
    int cycles;
    int low;
    int err_before;
    logic [ADDR_BITS-1:0] rev;
    logic [DATA_BITS-1:0] w;
    err_before = errors;
    fault_en = rows[r].fault_en;
    fault_addr = rows[r].fault_addr;
    stuck_data = rows[r].stuck;
    pulse_start(rows[r].read_only);
    compare_value("led_done after start", 32'(led_done), 32'd0);
    cycles = 1;
    seen = 1'b0;
    if (rows[r].extra_start) begin
      while (!seen && cycles < 32) begin
        @(negedge clk);
        cycles++;
        seen = !sram_we_n;
      end
      compare_value("write strobe before second start", 32'(seen), 32'd1);
      pulse_start(1'b1);
      cycles++;
      seen = 1'b0;
    end
    while (!seen && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = led_done;
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("Run %0d: led_done did not rise within %0d cycles", r, RUN_TIMEOUT);
    end else begin
      compare_value("led_pass", 32'(led_pass), 32'(rows[r].exp_pass));
      if (rows[r].exp_pass) begin
        compare_value("run covers the full sweep", 32'(cycles >= (rows[r].read_only ?
                      DEPTH * 4 : FULL_RUN)), 32'd1);
      end else begin
        rev = reverse_addr(rows[r].exp_fail_addr);
        w = addr_word(rows[r].exp_fail_addr);
        // Failure is always in the address pattern, which reverses to zero
        compare_value("ba_pins", 32'(ba_pins), 32'h0);
        compare_value("dc_pins", 32'(dc_pins), 32'(rev[ADDR_BITS-1:HALF]));
        compare_value("kl_pins", 32'(kl_pins), 32'(rev[HALF-1:0]));
        compare_value("hg_pins", 32'(hg_pins), 32'(w[GB-1:0]));
        compare_value("lk_pins", 32'(lk_pins), 32'(rows[r].exp_rd[GB-1:0]));
      end
      // A second rise would need led_done to drop first
      low = 0;
      for (int i = 0; i < HOLD_CYCLES; i++) begin
        @(negedge clk);
        if (!led_done) begin
          low++;
        end
      end
      compare_value("led_done held after the run", 32'(low), 32'd0);
    end
    $display("Run %0d read_only=%0b fault=%0b: %s", r, rows[r].read_only,
             rows[r].fault_en, (errors == err_before && seen) ? "ok" : "wrong");
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    read_only = 1'b0;
    fault_en = 1'b0;
    fault_addr = '0;
    stuck_data = '0;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compare_value("sram_cs_n after reset", 32'(sram_cs_n), 32'd1);
    compare_value("sram_oe_n after reset", 32'(sram_oe_n), 32'd1);
    compare_value("sram_we_n after reset", 32'(sram_we_n), 32'd1);
    compare_value("led_done after reset", 32'(led_done), 32'd0);
    $display("Reset state: %s", (errors == 0) ? "ok" : "wrong");
    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      run_row(r);
    end
    $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             UUT.u_asserts.fire_count);
    if (timed_out || errors != 0 || UUT.u_asserts.fire_count != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

// ==== verilog/debug_pin_mapper.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module debug_pin_mapper #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT
) (
  input  logic [ADDR_BITS-1:0]           addr,
  input  sram_test_pkg::pattern_t        pattern,
  input  logic [`DEBUG_GROUP_BITS-1:0]   lo_data_a,
  input  logic [`DEBUG_GROUP_BITS-1:0]   lo_data_b,
  output logic [`DEBUG_GROUP_BITS-1:0]   ba_pins,
  output logic [`DEBUG_GROUP_BITS-1:0]   dc_pins,
  output logic [`DEBUG_GROUP_BITS-1:0]   kl_pins,
  output logic [`DEBUG_GROUP_BITS-1:0]   hg_pins,
  output logic [`DEBUG_GROUP_BITS-1:0]   lk_pins
);

  localparam int GB = `DEBUG_GROUP_BITS;

  logic [ADDR_BITS-1:0] addr_rev;
  logic [2:0]           pattern_rev;

  // LEDs are wired MSB first on the board
  always_comb begin
    for (int i = 0; i < ADDR_BITS; i++) begin
      addr_rev[i] = addr[ADDR_BITS-1-i];
    end
    for (int j = 0; j < 3; j++) begin
      pattern_rev[j] = pattern[2-j];
    end
  end

  generate
    if (ADDR_BITS >= 20) begin : g_full_addr
      assign ba_pins = {addr_rev[3:0], 1'b0, pattern_rev};
      assign dc_pins = addr_rev[11:4];
      assign kl_pins = addr_rev[19:12];
    end else if (ADDR_BITS >= 16) begin : g_partial_addr
      assign ba_pins = {addr_rev[3:0], 1'b0, pattern_rev};
      assign dc_pins = addr_rev[11:4];
      assign kl_pins = {{(GB-(ADDR_BITS-12)){1'b0}}, addr_rev[ADDR_BITS-1:12]};
    end else begin : g_minimal_addr
      // Short addresses are split in halves over dc and kl
      assign ba_pins = {4'b0000, 1'b0, pattern_rev};
      assign dc_pins = {{(GB-(ADDR_BITS-ADDR_BITS/2)){1'b0}},
                        addr_rev[ADDR_BITS-1:ADDR_BITS/2]};
      assign kl_pins = {{(GB-ADDR_BITS/2){1'b0}}, addr_rev[ADDR_BITS/2-1:0]};
    end
  endgenerate

  assign hg_pins = lo_data_a;
  assign lk_pins = lo_data_b;

endmodule

// ==== verilog/pattern_gen.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module pattern_gen #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT,
  parameter int DATA_BITS = `SRAM_DATA_BITS_DEFAULT
) (
  input  sram_test_pkg::pattern_t pattern,
  input  logic [ADDR_BITS-1:0]    addr,
  output logic [DATA_BITS-1:0]    data
);

  logic [DATA_BITS-1:0] addr_word;
  logic [DATA_BITS-1:0] checker_word;

  // Address low bits fitted to the data width
  generate
    if (DATA_BITS > ADDR_BITS) begin : g_addr_extend
      assign addr_word = {{(DATA_BITS-ADDR_BITS){1'b0}}, addr};
    end else begin : g_addr_trunc
      assign addr_word = addr[DATA_BITS-1:0];
    end
  endgenerate

  // 0101... on even addresses, 1010... on odd
  always_comb begin
    for (int i = 0; i < DATA_BITS; i++) begin
      checker_word[i] = (i % 2 == 0) ^ addr[0];
    end
  end

  always_comb begin
    case (pattern)
      sram_test_pkg::PAT_ADDR:        data = addr_word;
      sram_test_pkg::PAT_ADDR_INV:    data = ~addr_word;
      sram_test_pkg::PAT_CHECKER:     data = checker_word;
      sram_test_pkg::PAT_CHECKER_INV: data = ~checker_word;
      default:                        data = '0;
    endcase
  end

endmodule

// ==== verilog/sram_bus_ctrl.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module sram_bus_ctrl #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT,
  parameter int DATA_BITS = `SRAM_DATA_BITS_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  op_req,
  input  sram_bus_pkg::bus_op_t op_kind,
  input  logic [ADDR_BITS-1:0]  op_addr,
  input  logic [DATA_BITS-1:0]  op_wdata,
  output logic                  op_done,
  output logic [DATA_BITS-1:0]  op_rdata,
  output logic [ADDR_BITS-1:0]  addr_bus,
  inout  wire  [DATA_BITS-1:0]  data_bus,
  output logic                  ce_n,
  output logic                  we_n,
  output logic                  oe_n
);

  sram_bus_pkg::bus_phase_t phase;
  sram_bus_pkg::bus_op_t    kind_q;
  logic [DATA_BITS-1:0]     wdata_q;
  logic                     data_oe;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= sram_bus_pkg::PH_IDLE;
    end else begin
      case (phase)
        sram_bus_pkg::PH_IDLE:   if (op_req) phase <= sram_bus_pkg::PH_SETUP;
        sram_bus_pkg::PH_SETUP:  phase <= sram_bus_pkg::PH_STROBE;
        sram_bus_pkg::PH_STROBE: phase <= sram_bus_pkg::PH_FINISH;
        default:                 phase <= sram_bus_pkg::PH_IDLE;
      endcase
    end
  end

  // Capture the request so the pins stay put for the whole cycle
  always_ff @(posedge clk) begin
    if (op_req && phase == sram_bus_pkg::PH_IDLE) begin
      kind_q   <= op_kind;
      addr_bus <= op_addr;
      wdata_q  <= op_wdata;
    end
    // Read data is taken at the end of the OE strobe
    if (phase == sram_bus_pkg::PH_STROBE && kind_q == sram_bus_pkg::BUS_READ) begin
      op_rdata <= data_bus;
    end
  end

  assign ce_n = (phase == sram_bus_pkg::PH_IDLE);
  assign we_n = !(phase == sram_bus_pkg::PH_STROBE && kind_q == sram_bus_pkg::BUS_WRITE);
  assign oe_n = !(phase == sram_bus_pkg::PH_STROBE && kind_q == sram_bus_pkg::BUS_READ);

  // Hold write data one phase past the WE strobe for hold time
  assign data_oe = (kind_q == sram_bus_pkg::BUS_WRITE) &&
                   (phase == sram_bus_pkg::PH_STROBE || phase == sram_bus_pkg::PH_FINISH);
  assign data_bus = data_oe ? wdata_q : {DATA_BITS{1'bz}};

  assign op_done = (phase == sram_bus_pkg::PH_FINISH);

endmodule

// ==== verilog/sram_bus_pkg.sv ====
package sram_bus_pkg;

  // Access requested from the bus controller
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_t;

  // Phases of one asynchronous SRAM cycle
  typedef enum logic [1:0] {
    PH_IDLE   = 2'd0,
    PH_SETUP  = 2'd1,
    PH_STROBE = 2'd2,
    PH_FINISH = 2'd3
  } bus_phase_t;

endpackage

// ==== verilog/sram_test_pkg.sv ====
package sram_test_pkg;

  // Sequencer state
  typedef enum logic [2:0] {
    TS_IDLE      = 3'd0,
    TS_WRITE     = 3'd1,
    TS_READ      = 3'd2,
    TS_NEXT      = 3'd3,
    TS_DONE_PASS = 3'd4,
    TS_DONE_FAIL = 3'd5
  } test_state_t;

  // Data pattern kinds, stepped through in this order
  typedef enum logic [2:0] {
    PAT_ADDR        = 3'd0,
    PAT_ADDR_INV    = 3'd1,
    PAT_CHECKER     = 3'd2,
    PAT_CHECKER_INV = 3'd3
  } pattern_t;

  localparam int PATTERN_COUNT = 4;

endpackage

// ==== verilog/sram_tester.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module sram_tester #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT,
  parameter int DATA_BITS = `SRAM_DATA_BITS_DEFAULT
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         run,
  input  logic                         ro_mode,
  output logic                         op_req,
  output sram_bus_pkg::bus_op_t        op_kind,
  output logic [ADDR_BITS-1:0]         op_addr,
  output logic [DATA_BITS-1:0]         op_wdata,
  input  logic                         op_done,
  input  logic [DATA_BITS-1:0]         op_rdata,
  output sram_test_pkg::pattern_t      pattern,
  output sram_test_pkg::test_state_t   state,
  output logic [ADDR_BITS-1:0]         addr,
  output logic [DATA_BITS-1:0]         exp_data,
  output logic [DATA_BITS-1:0]         rd_data,
  output logic                         finish,
  output logic                         mismatch
);

  logic [DATA_BITS-1:0] pattern_word;
  logic                 last_addr;
  logic                 last_pattern;

  pattern_gen #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) u_pattern_gen (
    .pattern(pattern),
    .addr   (addr),
    .data   (pattern_word)
  );

  assign last_addr    = (addr == {ADDR_BITS{1'b1}});
  // Read-only runs stop after the address pattern
  assign last_pattern = ro_mode ||
      (pattern == sram_test_pkg::pattern_t'(sram_test_pkg::PATTERN_COUNT - 1));

  assign op_kind  = (state == sram_test_pkg::TS_WRITE) ? sram_bus_pkg::BUS_WRITE
                                                       : sram_bus_pkg::BUS_READ;
  assign op_addr  = addr;
  assign op_wdata = pattern_word;
  assign exp_data = pattern_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= sram_test_pkg::TS_IDLE;
      pattern  <= sram_test_pkg::PAT_ADDR;
      addr     <= '0;
      op_req   <= 1'b0;
      finish   <= 1'b0;
      mismatch <= 1'b0;
    end else begin
      op_req <= 1'b0;
      finish <= 1'b0;
      case (state)
        sram_test_pkg::TS_WRITE: begin
          if (op_done) begin
            op_req <= 1'b1;
            if (last_addr) begin
              state <= sram_test_pkg::TS_READ;
              addr  <= '0;
            end else begin
              addr <= addr + ADDR_BITS'(1);
            end
          end
        end
        sram_test_pkg::TS_READ: begin
          if (op_done) begin
            if (op_rdata != pattern_word) begin
              // Stop here, addr keeps the failing location
              state    <= sram_test_pkg::TS_DONE_FAIL;
              finish   <= 1'b1;
              mismatch <= 1'b1;
            end else if (last_addr) begin
              state <= sram_test_pkg::TS_NEXT;
            end else begin
              addr   <= addr + ADDR_BITS'(1);
              op_req <= 1'b1;
            end
          end
        end
        sram_test_pkg::TS_NEXT: begin
          if (last_pattern) begin
            state  <= sram_test_pkg::TS_DONE_PASS;
            finish <= 1'b1;
          end else begin
            state   <= sram_test_pkg::TS_WRITE;
            pattern <= sram_test_pkg::pattern_t'(pattern + 3'd1);
            addr    <= '0;
            op_req  <= 1'b1;
          end
        end
        default: begin
          // Idle or done, wait for the next run
          if (run) begin
            state    <= ro_mode ? sram_test_pkg::TS_READ : sram_test_pkg::TS_WRITE;
            pattern  <= sram_test_pkg::PAT_ADDR;
            addr     <= '0;
            mismatch <= 1'b0;
            op_req   <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op_done && state == sram_test_pkg::TS_READ) begin
      rd_data <= op_rdata;
    end
  end

endmodule

// ==== verilog/sram_tester_top.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module sram_tester_top #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT,
  parameter int DATA_BITS = `SRAM_DATA_BITS_DEFAULT
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         read_only,
  output logic                         led_done,
  output logic                         led_pass,
  output logic [ADDR_BITS-1:0]         sram_addr_bus,
  inout  wire  [DATA_BITS-1:0]         sram_data_bus,
  output logic                         sram_cs_n,
  output logic                         sram_oe_n,
  output logic                         sram_we_n,
  output logic [`DEBUG_GROUP_BITS-1:0] ba_pins,
  output logic [`DEBUG_GROUP_BITS-1:0] dc_pins,
  output logic [`DEBUG_GROUP_BITS-1:0] kl_pins,
  output logic [`DEBUG_GROUP_BITS-1:0] hg_pins,
  output logic [`DEBUG_GROUP_BITS-1:0] lk_pins
);

  logic run, ro_mode, done, pass, finish, mismatch;
  logic op_req, op_done;
  sram_bus_pkg::bus_op_t   op_kind;
  sram_test_pkg::pattern_t pattern;
  logic [ADDR_BITS-1:0] addr, op_addr, first_addr, show_addr;
  logic [DATA_BITS-1:0] exp_data, rd_data, op_wdata, op_rdata;
  logic [DATA_BITS-1:0] first_exp, first_rd, show_exp, show_rd;
  logic                 show_fail;

  test_config_regs #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_regs (
    .clk(clk), .reset(reset), .start(start), .read_only(read_only),
    .finish(finish), .mismatch(mismatch),
    .fail_addr(addr), .fail_exp(exp_data), .fail_rd(rd_data),
    .run(run), .ro_mode(ro_mode), .busy(), .done(done), .pass(pass),
    .first_addr(first_addr), .first_exp(first_exp), .first_rd(first_rd)
  );

  sram_tester #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_tester (
    .clk(clk), .reset(reset), .run(run), .ro_mode(ro_mode),
    .op_req(op_req), .op_kind(op_kind), .op_addr(op_addr), .op_wdata(op_wdata),
    .op_done(op_done), .op_rdata(op_rdata), .pattern(pattern), .state(),
    .addr(addr), .exp_data(exp_data), .rd_data(rd_data),
    .finish(finish), .mismatch(mismatch)
  );

  sram_bus_ctrl #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) u_bus (
    .clk(clk), .reset(reset), .op_req(op_req), .op_kind(op_kind),
    .op_addr(op_addr), .op_wdata(op_wdata), .op_done(op_done), .op_rdata(op_rdata),
    .addr_bus(sram_addr_bus), .data_bus(sram_data_bus),
    .ce_n(sram_cs_n), .we_n(sram_we_n), .oe_n(sram_oe_n)
  );

  // Freeze the display on the first failure once the run has stopped
  assign show_fail = done && !pass;
  assign show_addr = show_fail ? first_addr : addr;
  assign show_exp  = show_fail ? first_exp : exp_data;
  assign show_rd   = show_fail ? first_rd : rd_data;

  debug_pin_mapper #(.ADDR_BITS(ADDR_BITS)) u_pins (
    .addr(show_addr), .pattern(pattern),
    .lo_data_a(show_exp[`DEBUG_GROUP_BITS-1:0]),
    .lo_data_b(show_rd[`DEBUG_GROUP_BITS-1:0]),
    .ba_pins(ba_pins), .dc_pins(dc_pins), .kl_pins(kl_pins),
    .hg_pins(hg_pins), .lk_pins(lk_pins)
  );

  assign led_done = done;
  assign led_pass = pass;

endmodule

// ==== verilog/test_config_regs.sv ====
`timescale 1ns/10ps
`include "sram_tester_macros.svh"

module test_config_regs #(
  parameter int ADDR_BITS = `SRAM_ADDR_BITS_DEFAULT,
  parameter int DATA_BITS = `SRAM_DATA_BITS_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 read_only,
  input  logic                 finish,
  input  logic                 mismatch,
  input  logic [ADDR_BITS-1:0] fail_addr,
  input  logic [DATA_BITS-1:0] fail_exp,
  input  logic [DATA_BITS-1:0] fail_rd,
  output logic                 run,
  output logic                 ro_mode,
  output logic                 busy,
  output logic                 done,
  output logic                 pass,
  output logic [ADDR_BITS-1:0] first_addr,
  output logic [DATA_BITS-1:0] first_exp,
  output logic [DATA_BITS-1:0] first_rd
);

  always_ff @(posedge clk) begin
    if (reset) begin
      run     <= 1'b0;
      ro_mode <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      pass    <= 1'b0;
    end else begin
      run <= 1'b0;
      // Starts during a run are dropped
      if (start && !busy) begin
        ro_mode <= read_only;
        run     <= 1'b1;
        busy    <= 1'b1;
        done    <= 1'b0;
        pass    <= 1'b0;
      end else if (finish && busy) begin
        busy <= 1'b0;
        done <= 1'b1;
        pass <= !mismatch;
      end
    end
  end

  // Failure snapshot, meaningful only when done and not passing
  always_ff @(posedge clk) begin
    if (finish) begin
      first_addr <= fail_addr;
      first_exp  <= fail_exp;
      first_rd   <= fail_rd;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/sram_test_pkg.sv
verilog/sram_bus_pkg.sv
verilog/pattern_gen.sv
verilog/sram_bus_ctrl.sv
verilog/test_config_regs.sv
verilog/debug_pin_mapper.sv
verilog/sram_tester.sv
verilog/sram_tester_top.sv
tb/sram_model.sv
tb/sram_tester_asserts.sv
tb/sram_tester_tb.sv
